// File: sme_pkg.sv
package sme_pkg;

    localparam int SME_SHARES      = 2;                          // Boolean shares per value
    localparam int SME_WIDTH       = 32;                         // Data path width
    localparam int SME_RNG_WORDS   = SME_SHARES * (SME_SHARES - 1) / 2; // One per domain pair
    localparam int SME_DOM_LATENCY = 1;                          // Register stages in DOM AND
    localparam int SME_ADR_W       = 3;                          // Wishbone word address bits

    typedef logic [SME_WIDTH-1:0] sme_share_t;                   // One share word
    typedef sme_share_t sme_shares_t [SME_SHARES];               // Full masked value

    typedef enum logic [1:0] {
        SME_OP_XOR = 2'd0,
        SME_OP_AND = 2'd1,
        SME_OP_OR  = 2'd2,
        SME_OP_NOT = 2'd3
    } sme_op_e;

    typedef enum logic [1:0] {
        SME_ALU_IDLE = 2'd0,
        SME_ALU_DOM  = 2'd1,                                     // Waiting on DOM register
        SME_ALU_DONE = 2'd2                                      // Result valid cycle
    } sme_alu_state_e;

    localparam logic [SME_ADR_W-1:0] SME_ADR_RS1_S0 = 3'd0;
    localparam logic [SME_ADR_W-1:0] SME_ADR_RS1_S1 = 3'd1;
    localparam logic [SME_ADR_W-1:0] SME_ADR_RS2_S0 = 3'd2;
    localparam logic [SME_ADR_W-1:0] SME_ADR_RS2_S1 = 3'd3;
    localparam logic [SME_ADR_W-1:0] SME_ADR_CTRL   = 3'd4;     // Opcode write starts op
    localparam logic [SME_ADR_W-1:0] SME_ADR_STATUS = 3'd5;     // {busy, done}
    localparam logic [SME_ADR_W-1:0] SME_ADR_RD_S0  = 3'd6;
    localparam logic [SME_ADR_W-1:0] SME_ADR_RD_S1  = 3'd7;

    localparam sme_share_t SME_LFSR_SEED = 32'h1bad_5eed;        // Any nonzero value
    localparam sme_share_t SME_LFSR_TAPS = 32'h8020_0003;        // x^32+x^22+x^2+x+1

endpackage

// File: sme_op_if.sv
interface sme_op_if;

    sme_pkg::sme_shares_t rs1;                                   // Operand A shares
    sme_pkg::sme_shares_t rs2;                                   // Operand B shares
    sme_pkg::sme_op_e     op;                                    // Latched opcode
    logic                 start;                                 // One-cycle launch pulse
    logic                 busy;                                  // ALU occupied

    modport src (
        output rs1,
        output rs2,
        output op,
        output start,
        input  busy
    );

    modport dst (
        input  rs1,
        input  rs2,
        input  op,
        input  start,
        output busy
    );

endinterface

// File: sme_wb_regs.sv
module sme_wb_regs (
    input  logic                                g_clk,
    input  logic                                i_rst_n,
    input  logic                                i_wb_cyc,
    input  logic                                i_wb_stb,
    input  logic                                i_wb_we,
    input  logic [sme_pkg::SME_ADR_W-1:0]       i_wb_adr,
    input  sme_pkg::sme_share_t                 i_wb_dat,
    output sme_pkg::sme_share_t                 o_wb_dat,
    output logic                                o_wb_ack,
    input  sme_pkg::sme_shares_t                i_rd,       // Refreshed result shares
    input  logic                                i_done,
    sme_op_if.src                               op
);

    sme_pkg::sme_shares_t rs1_q;                                 // Operand A share regs
    sme_pkg::sme_shares_t rs2_q;                                 // Operand B share regs
    sme_pkg::sme_op_e     op_q;
    sme_pkg::sme_share_t  rdata;                                 // Read mux output
    logic                 req;
    logic                 ctrl_wr;
    logic                 accept;
    logic                 start_q;

    assign req     = i_wb_cyc && i_wb_stb && !o_wb_ack;          // No re-accept in ack cycle
    assign ctrl_wr = req && i_wb_we && (i_wb_adr == sme_pkg::SME_ADR_CTRL);
    assign accept  = req && !(ctrl_wr && op.busy);               // Stall launch while busy

    always_ff @(posedge g_clk) begin
        if (!i_rst_n) begin
            o_wb_ack <= 1'b0;
            start_q  <= 1'b0;
            rs1_q    <= '{default: '0};
            rs2_q    <= '{default: '0};
            op_q     <= sme_pkg::SME_OP_XOR;
        end else begin
            o_wb_ack <= accept;                                  // Single-cycle ack
            start_q  <= accept && ctrl_wr;                       // Start lines up with ack
            if (accept && i_wb_we) begin
                case (i_wb_adr)
                    sme_pkg::SME_ADR_RS1_S0: rs1_q[0] <= i_wb_dat;
                    sme_pkg::SME_ADR_RS1_S1: rs1_q[1] <= i_wb_dat;
                    sme_pkg::SME_ADR_RS2_S0: rs2_q[0] <= i_wb_dat;
                    sme_pkg::SME_ADR_RS2_S1: rs2_q[1] <= i_wb_dat;
                    sme_pkg::SME_ADR_CTRL:   op_q <= sme_pkg::sme_op_e'(i_wb_dat[1:0]);
                    default: ;                                   // Status and results read-only
                endcase
            end
        end
    end

    always_comb begin
        case (i_wb_adr)
            sme_pkg::SME_ADR_RS1_S0: rdata = rs1_q[0];
            sme_pkg::SME_ADR_RS1_S1: rdata = rs1_q[1];
            sme_pkg::SME_ADR_RS2_S0: rdata = rs2_q[0];
            sme_pkg::SME_ADR_RS2_S1: rdata = rs2_q[1];
            sme_pkg::SME_ADR_CTRL:   rdata = {{(sme_pkg::SME_WIDTH-2){1'b0}}, op_q};
            sme_pkg::SME_ADR_STATUS: rdata = {{(sme_pkg::SME_WIDTH-2){1'b0}}, op.busy, i_done};
            sme_pkg::SME_ADR_RD_S0:  rdata = i_rd[0];
            default:                 rdata = i_rd[1];
        endcase
    end

    // Read data registered so it is valid while ack is high
    always_ff @(posedge g_clk) begin
        if (accept && !i_wb_we) begin
            o_wb_dat <= rdata;
        end
    end

    assign op.rs1   = rs1_q;
    assign op.rs2   = rs2_q;
    assign op.op    = op_q;
    assign op.start = start_q;

endmodule

// File: sme_rng_lfsr.sv
module sme_rng_lfsr (
    input  logic                g_clk,
    input  logic                i_rst_n,
    output sme_pkg::sme_share_t o_mask_dom,                      // DOM blinding word
    output sme_pkg::sme_share_t o_mask_ref                       // Output re-masking word
);

    localparam int HALF = sme_pkg::SME_WIDTH / 2;

    sme_pkg::sme_share_t state_q;

    // Galois form, right shift with taps folded in on a set LSB
    always_ff @(posedge g_clk) begin
        if (!i_rst_n) begin
            state_q <= sme_pkg::SME_LFSR_SEED;
        end else if (state_q[0]) begin
            state_q <= (state_q >> 1) ^ sme_pkg::SME_LFSR_TAPS;
        end else begin
            state_q <= state_q >> 1;
        end
    end

    assign o_mask_dom = state_q;
    assign o_mask_ref = {state_q[HALF-1:0], state_q[sme_pkg::SME_WIDTH-1:HALF]}; // Rotate by 16

endmodule

// File: sme_dom_and.sv
module sme_dom_and #(
    parameter int D = 2,                                         // Share count
    parameter int N = 32                                         // Bits per share
) (
    input  logic         g_clk,
    input  logic         i_en,                                   // Capture products
    input  logic [N-1:0] i_rng [D*(D-1)/2],                      // One word per domain pair
    input  logic [N-1:0] i_rs1 [D],
    input  logic [N-1:0] i_rs2 [D],
    output logic [N-1:0] o_rd  [D]
);

    for (genvar n = 0; n < N; n++) begin : gen_bit
        logic [D-1:0] x;                                         // Bit n of each rs1 share
        logic [D-1:0] y;                                         // Bit n of each rs2 share

        for (genvar i = 0; i < D; i++) begin : gen_dom
            logic [D-1:0] prod_d;                                // Blinded partial products
            logic [D-1:0] prod_q;

            assign x[i] = i_rs1[i][n];
            assign y[i] = i_rs2[i][n];

            // Pair (i,j) and (j,i) share one mask word so it cancels on recombination
            always_comb begin
                for (int j = 0; j < D; j++) begin
                    if (j == i) begin
                        prod_d[j] = x[i] & y[j];                 // Inner-domain term
                    end else if (j > i) begin
                        prod_d[j] = (x[i] & y[j]) ^ i_rng[i + j*(j-1)/2][n];
                    end else begin
                        prod_d[j] = (x[i] & y[j]) ^ i_rng[j + i*(i-1)/2][n];
                    end
                end
            end

            // Register stage keeps glitches from crossing domains
            always_ff @(posedge g_clk) begin
                if (i_en) begin
                    prod_q <= prod_d;
                end
            end

            assign o_rd[i][n] = ^prod_q;                         // Compress into share i
        end
    end

endmodule

// File: sme_masked_alu.sv
module sme_masked_alu (
    input  logic                 g_clk,
    input  logic                 i_rst_n,
    sme_op_if.dst                op,
    input  sme_pkg::sme_share_t  i_mask_dom,
    output logic                 o_res_valid,                    // One-cycle pulse
    output sme_pkg::sme_shares_t o_res
);

    sme_pkg::sme_alu_state_e state_q;
    sme_pkg::sme_op_e        op_q;                               // Opcode held through DOM stage
    logic                    is_dom_op;
    logic                    dom_en;
    sme_pkg::sme_shares_t    dom_a;                              // DOM gate inputs
    sme_pkg::sme_shares_t    dom_b;
    sme_pkg::sme_shares_t    dom_q;                              // DOM gate outputs
    sme_pkg::sme_shares_t    dom_res;
    sme_pkg::sme_shares_t    lin_res;                            // XOR and NOT result
    sme_pkg::sme_share_t     dom_rng [sme_pkg::SME_RNG_WORDS];

    assign is_dom_op = (op.op == sme_pkg::SME_OP_AND) || (op.op == sme_pkg::SME_OP_OR);
    assign dom_en    = op.start && is_dom_op;                    // Start only seen in idle

    for (genvar k = 0; k < sme_pkg::SME_RNG_WORDS; k++) begin : gen_rng
        assign dom_rng[k] = i_mask_dom;                          // Single pair with two shares
    end

    // Linear ops share by share, OR pre-inverts share 0 for De Morgan
    always_comb begin
        for (int s = 0; s < sme_pkg::SME_SHARES; s++) begin
            dom_a[s]   = op.rs1[s];
            dom_b[s]   = op.rs2[s];
            dom_res[s] = dom_q[s];
            if (op.op == sme_pkg::SME_OP_NOT) begin
                lin_res[s] = op.rs1[s];
            end else begin
                lin_res[s] = op.rs1[s] ^ op.rs2[s];
            end
        end
        if (op.op == sme_pkg::SME_OP_OR) begin
            dom_a[0] = ~op.rs1[0];
            dom_b[0] = ~op.rs2[0];
        end
        if (op.op == sme_pkg::SME_OP_NOT) begin
            lin_res[0] = ~op.rs1[0];                             // Flip one share only
        end
        if (op_q == sme_pkg::SME_OP_OR) begin
            dom_res[0] = ~dom_q[0];                              // Post-inversion
        end
    end

    sme_dom_and #(
        .D (sme_pkg::SME_SHARES),
        .N (sme_pkg::SME_WIDTH)
    ) sme_dom_and_i (
        .g_clk (g_clk),
        .i_en  (dom_en),
        .i_rng (dom_rng),
        .i_rs1 (dom_a),
        .i_rs2 (dom_b),
        .o_rd  (dom_q)
    );

    always_ff @(posedge g_clk) begin
        if (!i_rst_n) begin
            state_q <= sme_pkg::SME_ALU_IDLE;
            op_q    <= sme_pkg::SME_OP_XOR;
        end else begin
            case (state_q)
                sme_pkg::SME_ALU_IDLE: begin
                    if (op.start) begin
                        op_q    <= op.op;
                        state_q <= is_dom_op ? sme_pkg::SME_ALU_DOM : sme_pkg::SME_ALU_DONE;
                    end
                end
                sme_pkg::SME_ALU_DOM: state_q <= sme_pkg::SME_ALU_DONE; // DOM register loaded
                default: state_q <= sme_pkg::SME_ALU_IDLE;       // Done lasts one cycle
            endcase
        end
    end

    always_ff @(posedge g_clk) begin
        if (state_q == sme_pkg::SME_ALU_IDLE && op.start && !is_dom_op) begin
            o_res <= lin_res;
        end else if (state_q == sme_pkg::SME_ALU_DOM) begin
            o_res <= dom_res;
        end
    end

    assign o_res_valid = state_q == sme_pkg::SME_ALU_DONE;
    assign op.busy     = state_q != sme_pkg::SME_ALU_IDLE;       // Through the valid cycle

endmodule

// File: sme_share_refresh.sv
module sme_share_refresh (
    input  logic                 g_clk,
    input  logic                 i_rst_n,
    input  logic                 i_start,                        // Clears done
    input  logic                 i_res_valid,
    input  sme_pkg::sme_shares_t i_res,
    input  sme_pkg::sme_share_t  i_mask_ref,                     // Fresh mask this cycle
    output sme_pkg::sme_shares_t o_rd,
    output logic                 o_done
);

    // Same mask in both shares leaves the recombined value unchanged
    always_ff @(posedge g_clk) begin
        if (!i_rst_n) begin
            o_rd <= '{default: '0};
        end else if (i_res_valid) begin
            for (int s = 0; s < sme_pkg::SME_SHARES; s++) begin
                o_rd[s] <= i_res[s] ^ i_mask_ref;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (!i_rst_n) begin
            o_done <= 1'b0;
        end else if (i_res_valid) begin
            o_done <= 1'b1;                                      // Result stored
        end else if (i_start) begin
            o_done <= 1'b0;                                      // Next op launched
        end
    end

endmodule

// File: sme_masked_unit.sv
module sme_masked_unit (
    input  logic                          g_clk,
    input  logic                          i_rst_n,
    input  logic                          i_wb_cyc,
    input  logic                          i_wb_stb,
    input  logic                          i_wb_we,
    input  logic [sme_pkg::SME_ADR_W-1:0] i_wb_adr,
    input  logic [sme_pkg::SME_WIDTH-1:0] i_wb_dat,
    output logic [sme_pkg::SME_WIDTH-1:0] o_wb_dat,
    output logic                          o_wb_ack
);

    sme_pkg::sme_share_t  mask_dom;
    sme_pkg::sme_share_t  mask_ref;
    logic                 res_valid;
    sme_pkg::sme_shares_t res;                                   // ALU to refresh
    sme_pkg::sme_shares_t rd;                                    // Refresh to bus
    logic                 done;

    sme_op_if op_if ();                                          // Register file to ALU

    sme_wb_regs sme_wb_regs_i (
        .g_clk    (g_clk),
        .i_rst_n  (i_rst_n),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .i_rd     (rd),
        .i_done   (done),
        .op       (op_if.src)
    );

    sme_rng_lfsr sme_rng_lfsr_i (
        .g_clk      (g_clk),
        .i_rst_n    (i_rst_n),
        .o_mask_dom (mask_dom),
        .o_mask_ref (mask_ref)
    );

    sme_masked_alu sme_masked_alu_i (
        .g_clk       (g_clk),
        .i_rst_n     (i_rst_n),
        .op          (op_if.dst),
        .i_mask_dom  (mask_dom),
        .o_res_valid (res_valid),
        .o_res       (res)
    );

    sme_share_refresh sme_share_refresh_i (
        .g_clk       (g_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (op_if.start),                              // Done drops on launch
        .i_res_valid (res_valid),
        .i_res       (res),
        .i_mask_ref  (mask_ref),
        .o_rd        (rd),
        .o_done      (done)
    );

endmodule

// File: sme_masked_unit_chk.sv
module sme_masked_unit_chk (
    input logic g_clk,
    input logic i_rst_n,
    input logic i_wb_cyc,
    input logic i_wb_stb,
    input logic i_wb_ack,
    input logic i_start,                                         // Launch pulse to ALU
    input logic i_busy,
    input logic i_res_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    a_ack_single: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        i_wb_ack |=> !i_wb_ack) else $error("Wishbone ack held for two cycles");

    a_ack_req: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        i_wb_ack |-> $past(i_wb_cyc && i_wb_stb)) else $error("Wishbone ack without request");

    a_start_idle: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        i_start |-> !i_busy) else $error("ALU start while busy");

    // XOR/NOT take one cycle, AND/OR add the DOM stage
    a_valid_start: assert property (@(posedge g_clk) disable iff (!i_rst_n)
        i_res_valid |-> ($past(i_start) || $past(i_start, 1 + sme_pkg::SME_DOM_LATENCY)))
        else $error("Result without start");

endmodule

bind sme_masked_unit sme_masked_unit_chk sme_masked_unit_chk_i (
    .g_clk       (g_clk),
    .i_rst_n     (i_rst_n),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_ack    (o_wb_ack),
    .i_start     (op_if.start),
    .i_busy      (op_if.busy),
    .i_res_valid (res_valid)
);

// File: tb_sme_masked_unit.sv
module tb_sme_masked_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ENTRIES = 8;
    localparam int TIMEOUT     = NUM_ENTRIES * 40;               // Cycles before giving up

    logic        g_clk  = 1'b0;
    logic        rst_n  = 1'b0;
    logic        wb_cyc = 1'b0;
    logic        wb_stb = 1'b0;
    logic        wb_we  = 1'b0;
    logic [2:0]  wb_adr = '0;
    logic [31:0] wb_dat = '0;
    logic [31:0] wb_rdat;
    logic        wb_ack;
    int          seed   = 32'h45c9;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic        done_prev = 1'b0;
    sme_pkg::sme_share_t done_vals [$];                          // Recombined result per completion

    string             tbl_name [NUM_ENTRIES] = '{"xor_mix", "and_mix", "or_mix", "not_mix",
                                                  "and_ones", "or_zero", "xor_self", "not_zero"};
    logic [31:0]       tbl_a [NUM_ENTRIES] = '{32'hdead_beef, 32'hf0f0_a5a5, 32'h1234_0000,
                                               32'hcafe_f00d, 32'hffff_ffff, 32'h0000_0000,
                                               32'h5a5a_5a5a, 32'h0000_0000};
    logic [31:0]       tbl_b [NUM_ENTRIES] = '{32'h0123_4567, 32'h0ff0_ffff, 32'h0000_abcd,
                                               32'h0000_0000, 32'h8765_4321, 32'h0000_0000,
                                               32'h5a5a_5a5a, 32'h3c3c_1111};
    sme_pkg::sme_op_e  tbl_op [NUM_ENTRIES] = '{sme_pkg::SME_OP_XOR, sme_pkg::SME_OP_AND,
                                               sme_pkg::SME_OP_OR, sme_pkg::SME_OP_NOT,
                                               sme_pkg::SME_OP_AND, sme_pkg::SME_OP_OR,
                                               sme_pkg::SME_OP_XOR, sme_pkg::SME_OP_NOT};

    sme_masked_unit sme_masked_unit_i (
        .g_clk    (g_clk),
        .i_rst_n  (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_we  (wb_we),
        .i_wb_adr (wb_adr),
        .i_wb_dat (wb_dat),
        .o_wb_dat (wb_rdat),
        .o_wb_ack (wb_ack)
    );

    always #10 g_clk = ~g_clk;                                   // 20 ns period

    // Record every rising done, in completion order
    always @(negedge g_clk) begin
        if (sme_masked_unit_i.done && !done_prev) begin
            done_vals.push_back(sme_masked_unit_i.rd[0] ^ sme_masked_unit_i.rd[1]);
        end
        done_prev = sme_masked_unit_i.done;
    end

    always @(posedge g_clk) begin
        cycles++;
        if (cycles == TIMEOUT) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT);
            errors++;
            finish_run();
        end
    end

    task automatic finish_run();
        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Called on a falling edge, returns on the falling edge where ack is seen
    task automatic bus_xfer(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        wb_dat = wdat;
        do @(negedge g_clk); while (!wb_ack);
        rdat   = wb_rdat;                                        // Valid while ack high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic reg_write(input logic [2:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_xfer(1'b1, adr, wdat, unused);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic read_check(input string name, input logic [2:0] adr, input logic [31:0] exp);
        logic [31:0] rdat;
        bus_xfer(1'b0, adr, '0, rdat);
        check_val(name, exp, rdat);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        st = '0;
        while (st[0] !== 1'b1) bus_xfer(1'b0, sme_pkg::SME_ADR_STATUS, '0, st); // Poll done bit
    endtask

    task automatic load_operands(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] s0a;
        logic [31:0] s0b;
        s0a = $random(seed);                                     // Fresh share 0 per operand
        s0b = $random(seed);
        reg_write(sme_pkg::SME_ADR_RS1_S0, s0a);
        reg_write(sme_pkg::SME_ADR_RS1_S1, a ^ s0a);
        reg_write(sme_pkg::SME_ADR_RS2_S0, s0b);
        reg_write(sme_pkg::SME_ADR_RS2_S1, b ^ s0b);
    endtask

    function automatic logic [31:0] model_op(input logic [31:0] a, input logic [31:0] b,
                                             input sme_pkg::sme_op_e opc);
        case (opc)
            sme_pkg::SME_OP_XOR: return a ^ b;
            sme_pkg::SME_OP_AND: return a & b;
            sme_pkg::SME_OP_OR:  return a | b;
            default:             return ~a;
        endcase
    endfunction

    initial begin
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] exp;
        repeat (2) @(posedge g_clk);                             // Two reset cycles
        @(negedge g_clk);
        rst_n = 1'b1;
        for (int adr = 0; adr < 8; adr++) begin
            read_check($sformatf("reset_adr%0d", adr), 3'(adr), '0); // All regs clear
        end
        for (int adr = 0; adr < 4; adr++) begin
            reg_write(3'(adr), 32'h9e37_79b9 ^ {4{8'(adr)}});
            read_check($sformatf("share_rw%0d", adr), 3'(adr), 32'h9e37_79b9 ^ {4{8'(adr)}});
        end
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            load_operands(tbl_a[k], tbl_b[k]);
            reg_write(sme_pkg::SME_ADR_CTRL, 32'(tbl_op[k]));
            wait_done();
            bus_xfer(1'b0, sme_pkg::SME_ADR_RD_S0, '0, r0);
            bus_xfer(1'b0, sme_pkg::SME_ADR_RD_S1, '0, r1);
            exp = model_op(tbl_a[k], tbl_b[k], tbl_op[k]);
            check_val(tbl_name[k], exp, r0 ^ r1);
            if (tbl_op[k] == sme_pkg::SME_OP_AND && tbl_a[k] != 0 && tbl_b[k] != 0) begin
                checks++;
                if ((r0 == exp && r1 == 0) || (r1 == exp && r0 == 0)) begin
                    errors++;
                    $display("ERROR: %s result shares %h %h are not masked", tbl_name[k], r0, r1);
                end
            end
        end
        // Second launch must stall until the first result lands
        done_vals.delete();
        load_operands(32'hc3a5_0ff1, 32'h7e81_9d2c);
        reg_write(sme_pkg::SME_ADR_CTRL, 32'(sme_pkg::SME_OP_AND));
        reg_write(sme_pkg::SME_ADR_CTRL, 32'(sme_pkg::SME_OP_XOR));
        checks++;
        if (sme_masked_unit_i.done !== 1'b1) begin
            errors++;
            $display("ERROR: second control write was accepted before the first result was done");
        end
        wait_done();
        bus_xfer(1'b0, sme_pkg::SME_ADR_RD_S0, '0, r0);
        bus_xfer(1'b0, sme_pkg::SME_ADR_RD_S1, '0, r1);
        check_val("b2b_second_read", 32'hc3a5_0ff1 ^ 32'h7e81_9d2c, r0 ^ r1);
        checks++;
        if (done_vals.size() != 2) begin
            errors++;
            $display("ERROR: expected two completed results but saw %0d", done_vals.size());
        end else begin
            check_val("b2b_first", 32'hc3a5_0ff1 & 32'h7e81_9d2c, done_vals[0]);
            check_val("b2b_second", 32'hc3a5_0ff1 ^ 32'h7e81_9d2c, done_vals[1]);
        end
        finish_run();
    end

endmodule

// File: sme_masked_unit.f
sme_pkg.sv
sme_op_if.sv
sme_wb_regs.sv
sme_rng_lfsr.sv
sme_dom_and.sv
sme_masked_alu.sv
sme_share_refresh.sv
sme_masked_unit.sv
sme_masked_unit_chk.sv
tb_sme_masked_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the masked unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_sme_masked_unit -f sme_masked_unit.f \
    -Mdir obj_dir -o vtb_sme_masked_unit > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/vtb_sme_masked_unit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
